//--- bench/tb_exec_subsys.sv
`timescale 1ns/10ps

module tb_exec_subsys
    import isa_pkg::*, pipe_pkg::*;
;

    localparam int NROWS = 24;

    typedef struct packed {
        logic [31:0] instr, pc, rs, rt;
        logic [1:0]  fa, fb;
        logic [31:0] md, wd;
        logic        flush, rnd;
    } row_t;

    logic            i_clk;
    logic            i_rst;
    instr_u          i_instr;
    logic [XLEN-1:0] i_pc, i_rs_data, i_rt_data;
    fwd_sel_e        i_fwd_a, i_fwd_b;
    logic [XLEN-1:0] i_fwd_mem_data, i_fwd_wb_data;
    logic            i_flush;
    ex_out_t         o_ex;
    logic [XLEN-1:0] o_branch_target;

    row_t        tbl [NROWS];
    row_t        cur;
    ex_out_t     exp_ex;
    logic [31:0] exp_tgt, prev_tgt;
    int          n_pass, n_fail, row_err, cnt;

    exec_subsys_top UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Watchdog on the whole run
    initial begin
        #200us;
        $display("Simulation ran past its time limit");
        $display("Something failed");
        $finish;
    end

    // R-type with rs=1 rt=2
    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd, sh);
        return {OP_RTYPE, 5'd1, 5'd2, rd, sh, fn};
    endfunction

    // I-type with rs=4 rt=5
    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [15:0] imm);
        return {op, 5'd4, 5'd5, imm};
    endfunction

    function automatic logic [31:0] pick(input logic [1:0] sel, input logic [31:0] r, m, w);
        return (sel == 2'd1) ? m : (sel == 2'd2) ? w : r;
    endfunction

    task automatic put_row(input int k, input logic [31:0] instr, pc, rs, rt, input logic rnd);
        tbl[k] = '{instr, pc, rs, rt, 2'd0, 2'd0, 32'h0, 32'h0, 1'b0, rnd};
    endtask

    // Expected outputs straight from the instruction set rules
    task automatic model(input row_t r);
        logic [5:0]  op, fn;
        logic [4:0]  sh;
        logic [31:0] a, b, ext, res;
        op = r.instr[31:26];
        fn = r.instr[5:0];
        sh = r.instr[10:6];
        a = pick(r.fa, r.rs, r.md, r.wd);
        b = pick(r.fb, r.rt, r.md, r.wd);
        ext = {{16{r.instr[15]}}, r.instr[15:0]};
        if (op == OP_ANDI || op == OP_ORI || op == OP_XORI)
            ext = {16'h0, r.instr[15:0]};
        exp_ex = '0;
        exp_ex.write_reg = r.instr[20:16];
        exp_ex.write_data = b;
        res = a + ext;
        case (op)
            OP_RTYPE: begin
                exp_ex.write_reg = r.instr[15:11];
                exp_ex.wb = 2'b10;
                case (fn)
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = {31'h0, $signed(a) < $signed(b)};
                    FN_SLTU: res = {31'h0, a < b};
                    FN_SLL:  res = b << sh;
                    FN_SRL:  res = b >> sh;
                    FN_SRA:  res = $unsigned($signed(b) >>> sh);
                    default: res = a + b;
                endcase
            end
            OP_ADDIU: exp_ex.wb = 2'b10;
            OP_ANDI: begin
                res = a & ext;
                exp_ex.wb = 2'b10;
            end
            OP_ORI: begin
                res = a | ext;
                exp_ex.wb = 2'b10;
            end
            OP_XORI: begin
                res = a ^ ext;
                exp_ex.wb = 2'b10;
            end
            OP_SLTI: begin
                res = {31'h0, $signed(a) < $signed(ext)};
                exp_ex.wb = 2'b10;
            end
            OP_LUI: begin
                res = {r.instr[15:0], 16'h0};
                exp_ex.wb = 2'b10;
            end
            OP_LW: begin
                exp_ex.mem = {1'b0, 1'b0, 1'b1, 1'b0, 2'd2, 1'b0, 2'b00};
                exp_ex.wb = 2'b11;
            end
            OP_SW: exp_ex.mem = {1'b0, 1'b0, 1'b0, 1'b1, 2'd2, 1'b0, 2'b00};
            OP_BEQ: begin
                res = a - b;
                exp_ex.mem = {2'b10, 7'h0};
            end
            OP_BNE: begin
                res = a - b;
                exp_ex.mem = {2'b01, 7'h0};
            end
            default: res = a + b;
        endcase
        exp_ex.alu_result = res;
        exp_ex.zero = (res == 32'h0);
        if (r.flush) begin
            exp_ex.mem = '0;
            exp_ex.wb = '0;
        end
        exp_tgt = r.pc + 32'd4 + (ext << 2);
    endtask

    task automatic check(input string name, input logic [31:0] exp, got);
        assert (exp === got) else begin
            $display("Error %s expected 0x%h got 0x%h", name, exp, got);
            row_err++;
        end
    endtask

    task automatic report(input string name);
        if (row_err == 0) begin
            $display("Test %s passed", name);
            n_pass++;
        end else begin
            $display("Test %s failed with %0d errors", name, row_err);
            n_fail++;
        end
    endtask

    initial begin
        void'($urandom(32'h35995d57));
        i_rst = 1'b0;
        i_instr = '0;
        i_pc = '0;
        i_rs_data = '0;
        i_rt_data = '0;
        i_fwd_a = FWD_REGFILE;
        i_fwd_b = FWD_REGFILE;
        i_fwd_mem_data = '0;
        i_fwd_wb_data = '0;
        i_flush = 1'b0;
        n_pass = 0;
        n_fail = 0;

        put_row(0, r_word(FN_ADDU, 5'd3, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(1, r_word(FN_SUBU, 5'd4, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(2, r_word(FN_AND, 5'd5, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(3, r_word(FN_OR, 5'd6, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(4, r_word(FN_XOR, 5'd7, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(5, r_word(FN_NOR, 5'd8, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(6, r_word(FN_SLT, 5'd9, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(7, r_word(FN_SLTU, 5'd10, 5'd0), 32'h0, 32'h0, 32'h0, 1'b1);
        put_row(8, r_word(FN_SLL, 5'd11, 5'd7), 32'h0, 32'h0, 32'h800000f1, 1'b0);
        put_row(9, r_word(FN_SRL, 5'd12, 5'd4), 32'h0, 32'h0, 32'h800000f1, 1'b0);
        put_row(10, r_word(FN_SRA, 5'd13, 5'd4), 32'h0, 32'h0, 32'h800000f1, 1'b0);
        put_row(11, i_word(OP_ADDIU, 16'hfff0), 32'h0, 32'h100, 32'h0, 1'b0);
        put_row(12, i_word(OP_ANDI, 16'hf0f0), 32'h0, 32'hffffffff, 32'h0, 1'b0);
        put_row(13, i_word(OP_ORI, 16'h8001), 32'h0, 32'h12340000, 32'h0, 1'b0);
        put_row(14, i_word(OP_XORI, 16'hffff), 32'h0, 32'h0000ff00, 32'h0, 1'b0);
        put_row(15, i_word(OP_SLTI, 16'hffff), 32'h0, 32'hfffffffe, 32'h0, 1'b0);
        put_row(16, i_word(OP_LUI, 16'hbeef), 32'h0, 32'h0, 32'h0, 1'b0);
        put_row(17, i_word(OP_LW, 16'hfffc), 32'h0, 32'h1000, 32'h0, 1'b0);
        put_row(18, i_word(OP_SW, 16'h0010), 32'h0, 32'h2000, 32'hcafef00d, 1'b0);
        put_row(19, i_word(OP_BEQ, 16'hfffe), 32'h400, 32'h5, 32'h5, 1'b0);
        put_row(20, i_word(OP_BNE, 16'h0010), 32'h800, 32'h5, 32'h6, 1'b0);
        put_row(21, r_word(FN_ADDU, 5'd14, 5'd0), 32'h0, 32'h1, 32'h2, 1'b0);
        put_row(22, r_word(FN_ADDU, 5'd15, 5'd0), 32'h0, 32'h10, 32'h20, 1'b0);
        put_row(23, i_word(OP_LW, 16'h0008), 32'h0, 32'h3000, 32'h0, 1'b0);
        // Forwarding and flush cases
        tbl[18].fb = 2'd1;
        tbl[18].md = 32'h000055aa;
        tbl[20].fa = 2'd2;
        tbl[20].wd = 32'h6;
        tbl[21].fa = 2'd1;
        tbl[21].fb = 2'd2;
        tbl[21].md = 32'h11110000;
        tbl[21].wd = 32'h00002222;
        tbl[22].fa = 2'd3;
        tbl[22].flush = 1'b1;
        tbl[23].flush = 1'b1;

        repeat (3) @(posedge i_clk);
        i_rst <= 1'b1;
        cnt = 0;
        do begin
            @(negedge i_clk);
            cnt++;
        end while (i_rst !== 1'b1 && cnt < 20);
        if (i_rst !== 1'b1) begin
            $display("Reset was never released");
            $display("Something failed");
            $finish;
        end
        // Register still holds the cleared record here
        row_err = 0;
        check("reg_write", 32'h0, 32'(o_ex.wb.reg_write));
        check("mem_read", 32'h0, 32'(o_ex.mem.mem_read));
        check("mem_write", 32'h0, 32'(o_ex.mem.mem_write));
        check("branch_eq", 32'h0, 32'(o_ex.mem.branch_eq));
        check("branch_ne", 32'h0, 32'(o_ex.mem.branch_ne));
        check("branch_target", 32'h0, o_branch_target);
        report("reset");

        // Idle all-zero word has pc 0 and no offset
        prev_tgt = 32'd4;

        for (int k = 0; k < NROWS; k++) begin
            cur = tbl[k];
            if (cur.rnd) begin
                cur.rs = $urandom;
                cur.rt = $urandom;
            end
            model(cur);
            row_err = 0;
            @(posedge i_clk);
            i_instr <= cur.instr;
            i_pc <= cur.pc;
            i_rs_data <= cur.rs;
            i_rt_data <= cur.rt;
            // Item now sits in execute
            @(posedge i_clk);
            i_fwd_a <= fwd_sel_e'(cur.fa);
            i_fwd_b <= fwd_sel_e'(cur.fb);
            i_fwd_mem_data <= cur.md;
            i_fwd_wb_data <= cur.wd;
            i_flush <= cur.flush;
            @(negedge i_clk);
            check("alu_result", exp_ex.alu_result, o_ex.alu_result);
            check("zero", 32'(exp_ex.zero), 32'(o_ex.zero));
            check("write_data", exp_ex.write_data, o_ex.write_data);
            check("write_reg", 32'(exp_ex.write_reg), 32'(o_ex.write_reg));
            check("mem", 32'(exp_ex.mem), 32'(o_ex.mem));
            check("wb", 32'(exp_ex.wb), 32'(o_ex.wb));
            // Target still belongs to the older item
            check("branch_target", prev_tgt, o_branch_target);
            @(negedge i_clk);
            check("branch_target", exp_tgt, o_branch_target);
            prev_tgt = exp_tgt;
            report($sformatf("row %0d", k));
        end

        $display("Passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/alu.sv
rtl/alu_control.sv
rtl/instr_decode.sv
rtl/id_ex_reg.sv
rtl/seg_execute.sv
rtl/exec_subsys_top.sv
bench/tb_exec_subsys.sv

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu
    import isa_pkg::*, pipe_pkg::*;
(
    input  alu_fn_e         i_alu_fn,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result,
    output logic            o_zero
);

    logic [NB_REG-1:0] shamt;

    // Only the low bits of B count for shifts
    assign shamt = i_b[NB_REG-1:0];

    always_comb begin
        case (i_alu_fn)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_NOR:  o_result = ~(i_a | i_b);
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
            ALU_LUI:  o_result = {i_b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
            default:  o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

//--- rtl/alu_control.sv
`timescale 1ns/10ps

module alu_control
    import isa_pkg::*, pipe_pkg::*;
(
    input  alu_op_e             i_alu_op,
    input  logic [NB_FUNCT-1:0] i_funct,
    output alu_fn_e             o_alu_fn
);

    always_comb begin
        case (i_alu_op)
            AOP_ADD: o_alu_fn = ALU_ADD;
            AOP_SUB: o_alu_fn = ALU_SUB;
            AOP_AND: o_alu_fn = ALU_AND;
            AOP_OR:  o_alu_fn = ALU_OR;
            AOP_XOR: o_alu_fn = ALU_XOR;
            AOP_SLT: o_alu_fn = ALU_SLT;
            AOP_LUI: o_alu_fn = ALU_LUI;
            AOP_FUNCT: begin
                // R-type picks its function from funct
                case (i_funct)
                    FN_ADDU: o_alu_fn = ALU_ADD;
                    FN_SUBU: o_alu_fn = ALU_SUB;
                    FN_AND:  o_alu_fn = ALU_AND;
                    FN_OR:   o_alu_fn = ALU_OR;
                    FN_XOR:  o_alu_fn = ALU_XOR;
                    FN_NOR:  o_alu_fn = ALU_NOR;
                    FN_SLT:  o_alu_fn = ALU_SLT;
                    FN_SLTU: o_alu_fn = ALU_SLTU;
                    FN_SLL:  o_alu_fn = ALU_SLL;
                    FN_SRL:  o_alu_fn = ALU_SRL;
                    FN_SRA:  o_alu_fn = ALU_SRA;
                    default: o_alu_fn = ALU_ADD;
                endcase
            end
            default: o_alu_fn = ALU_ADD;
        endcase
    end

endmodule

//--- rtl/exec_subsys_top.sv
`timescale 1ns/10ps

module exec_subsys_top
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  instr_u          i_instr,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_rs_data,
    input  logic [XLEN-1:0] i_rt_data,
    input  fwd_sel_e        i_fwd_a,
    input  fwd_sel_e        i_fwd_b,
    input  logic [XLEN-1:0] i_fwd_mem_data,
    input  logic [XLEN-1:0] i_fwd_wb_data,
    input  logic            i_flush,
    output ex_out_t         o_ex,
    output logic [XLEN-1:0] o_branch_target
);

    // Decoded item and its registered copy
    id_ex_t rec_id;
    id_ex_t rec_ex;

    instr_decode u_instr_decode (
        .i_instr   (i_instr),
        .i_pc      (i_pc),
        .i_rs_data (i_rs_data),
        .i_rt_data (i_rt_data),
        .o_rec     (rec_id)
    );

    id_ex_reg u_id_ex_reg (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_rec (rec_id),
        .o_rec (rec_ex)
    );

    seg_execute u_seg_execute (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_rec           (rec_ex),
        .i_fwd_a         (i_fwd_a),
        .i_fwd_b         (i_fwd_b),
        .i_fwd_mem_data  (i_fwd_mem_data),
        .i_fwd_wb_data   (i_fwd_wb_data),
        .i_flush         (i_flush),
        .o_ex            (o_ex),
        .o_branch_target (o_branch_target)
    );

endmodule

//--- rtl/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg
    import pipe_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  id_ex_t i_rec,
    output id_ex_t o_rec
);

    // An all-zero record decodes as a bubble
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_rec <= '0;
        end else begin
            o_rec <= i_rec;
        end
    end

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/10ps

module instr_decode
    import isa_pkg::*, pipe_pkg::*;
(
    input  instr_u          i_instr,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_rs_data,
    input  logic [XLEN-1:0] i_rt_data,
    output id_ex_t          o_rec
);

    logic [NB_IMM-1:0] imm;
    logic              zero_ext;

    assign imm = i_instr.i.imm;

    // Logical immediates are unsigned
    assign zero_ext = (i_instr.i.opcode == OP_ANDI) ||
                      (i_instr.i.opcode == OP_ORI)  ||
                      (i_instr.i.opcode == OP_XORI);

    always_comb begin
        o_rec         = '0;
        o_rec.pc      = i_pc;
        o_rec.rs_data = i_rs_data;
        o_rec.rt_data = i_rt_data;
        o_rec.funct   = i_instr.r.funct;
        o_rec.rt      = i_instr.i.rt;
        o_rec.rd      = i_instr.r.rd;
        o_rec.shamt   = i_instr.r.shamt;

        if (zero_ext) begin
            o_rec.imm_ext = {{(XLEN-NB_IMM){1'b0}}, imm};
        end else begin
            o_rec.imm_ext = {{(XLEN-NB_IMM){imm[NB_IMM-1]}}, imm};
        end

        case (i_instr.r.opcode)
            OP_RTYPE: begin
                o_rec.ex.alu_op    = AOP_FUNCT;
                o_rec.ex.reg_dst   = 1'b1;
                o_rec.ex.shift_imm = (i_instr.r.funct == FN_SLL) ||
                                     (i_instr.r.funct == FN_SRL) ||
                                     (i_instr.r.funct == FN_SRA);
                o_rec.wb.reg_write = 1'b1;
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI: begin
                o_rec.ex.b_imm     = 1'b1;
                o_rec.wb.reg_write = 1'b1;
                case (i_instr.i.opcode)
                    OP_ANDI: o_rec.ex.alu_op = AOP_AND;
                    OP_ORI:  o_rec.ex.alu_op = AOP_OR;
                    OP_XORI: o_rec.ex.alu_op = AOP_XOR;
                    OP_SLTI: o_rec.ex.alu_op = AOP_SLT;
                    OP_LUI:  o_rec.ex.alu_op = AOP_LUI;
                    default: o_rec.ex.alu_op = AOP_ADD;
                endcase
            end
            OP_LW: begin
                o_rec.ex.b_imm      = 1'b1;
                o_rec.ex.alu_op     = AOP_ADD;
                o_rec.mem.mem_read  = 1'b1;
                o_rec.mem.mem_size  = MSIZE_WORD;
                o_rec.wb.reg_write  = 1'b1;
                o_rec.wb.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                o_rec.ex.b_imm      = 1'b1;
                o_rec.ex.alu_op     = AOP_ADD;
                o_rec.mem.mem_write = 1'b1;
                o_rec.mem.mem_size  = MSIZE_WORD;
            end
            // Compare by subtraction, equality shows on zero
            OP_BEQ: begin
                o_rec.ex.alu_op     = AOP_SUB;
                o_rec.mem.branch_eq = 1'b1;
            end
            OP_BNE: begin
                o_rec.ex.alu_op     = AOP_SUB;
                o_rec.mem.branch_ne = 1'b1;
            end
            default: begin
                o_rec.ex  = '0;
                o_rec.mem = '0;
                o_rec.wb  = '0;
            end
        endcase
    end

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

    // Datapath and register address widths
    localparam int XLEN      = 32;
    localparam int NB_REG    = 5;
    localparam int NB_OPCODE = 6;
    localparam int NB_FUNCT  = 6;
    localparam int NB_IMM    = 16;

    // Primary opcodes
    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;
    localparam logic [NB_OPCODE-1:0] OP_BNE   = 6'h05;
    localparam logic [NB_OPCODE-1:0] OP_ADDIU = 6'h09;
    localparam logic [NB_OPCODE-1:0] OP_SLTI  = 6'h0a;
    localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0c;
    localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0d;
    localparam logic [NB_OPCODE-1:0] OP_XORI  = 6'h0e;
    localparam logic [NB_OPCODE-1:0] OP_LUI   = 6'h0f;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2b;

    // Function codes for R-type
    localparam logic [NB_FUNCT-1:0] FN_SLL  = 6'h00;
    localparam logic [NB_FUNCT-1:0] FN_SRL  = 6'h02;
    localparam logic [NB_FUNCT-1:0] FN_SRA  = 6'h03;
    localparam logic [NB_FUNCT-1:0] FN_ADDU = 6'h21;
    localparam logic [NB_FUNCT-1:0] FN_SUBU = 6'h23;
    localparam logic [NB_FUNCT-1:0] FN_AND  = 6'h24;
    localparam logic [NB_FUNCT-1:0] FN_OR   = 6'h25;
    localparam logic [NB_FUNCT-1:0] FN_XOR  = 6'h26;
    localparam logic [NB_FUNCT-1:0] FN_NOR  = 6'h27;
    localparam logic [NB_FUNCT-1:0] FN_SLT  = 6'h2a;
    localparam logic [NB_FUNCT-1:0] FN_SLTU = 6'h2b;

    // Register format
    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        logic [NB_REG-1:0]    rs;
        logic [NB_REG-1:0]    rt;
        logic [NB_REG-1:0]    rd;
        logic [NB_REG-1:0]    shamt;
        logic [NB_FUNCT-1:0]  funct;
    } instr_r_t;

    // Immediate format
    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        logic [NB_REG-1:0]    rs;
        logic [NB_REG-1:0]    rt;
        logic [NB_IMM-1:0]    imm;
    } instr_i_t;

    // Same 32-bit word read either way
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

//--- rtl/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    localparam int NB_ALU_OP = 4;
    localparam int NB_ALU_FN = 4;
    localparam int NB_FWD    = 2;

    // Word access size for loads and stores
    localparam logic [1:0] MSIZE_WORD = 2'd2;

    // Operation requested by decode
    typedef enum logic [NB_ALU_OP-1:0] {
        AOP_ADD   = 4'd0,
        AOP_SUB   = 4'd1,
        AOP_AND   = 4'd2,
        AOP_OR    = 4'd3,
        AOP_XOR   = 4'd4,
        AOP_SLT   = 4'd5,
        AOP_LUI   = 4'd6,
        AOP_FUNCT = 4'd7
    } alu_op_e;

    // Function carried out by the ALU
    typedef enum logic [NB_ALU_FN-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_fn_e;

    // Code 3 is treated as register file
    typedef enum logic [NB_FWD-1:0] {
        FWD_REGFILE = 2'd0,
        FWD_MEM     = 2'd1,
        FWD_WB      = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic    b_imm;
        logic    shift_imm;
        alu_op_e alu_op;
        logic    reg_dst;
    } ctrl_ex_t;

    typedef struct packed {
        logic       branch_eq;
        logic       branch_ne;
        logic       mem_read;
        logic       mem_write;
        logic [1:0] mem_size;
        logic       mem_unsigned;
        logic [1:0] rsvd;
    } ctrl_mem_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } ctrl_wb_t;

    // Item held between decode and execute
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     rs_data;
        logic [XLEN-1:0]     rt_data;
        logic [XLEN-1:0]     imm_ext;
        logic [NB_FUNCT-1:0] funct;
        logic [NB_REG-1:0]   rt;
        logic [NB_REG-1:0]   rd;
        logic [NB_REG-1:0]   shamt;
        ctrl_ex_t            ex;
        ctrl_mem_t           mem;
        ctrl_wb_t            wb;
    } id_ex_t;

    // Results leaving execute
    typedef struct packed {
        logic [XLEN-1:0]   alu_result;
        logic              zero;
        logic [XLEN-1:0]   write_data;
        logic [NB_REG-1:0] write_reg;
        ctrl_mem_t         mem;
        ctrl_wb_t          wb;
    } ex_out_t;

endpackage

//--- rtl/seg_execute.sv
`timescale 1ns/10ps

module seg_execute
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  id_ex_t          i_rec,
    input  fwd_sel_e        i_fwd_a,
    input  fwd_sel_e        i_fwd_b,
    input  logic [XLEN-1:0] i_fwd_mem_data,
    input  logic [XLEN-1:0] i_fwd_wb_data,
    input  logic            i_flush,
    output ex_out_t         o_ex,
    output logic [XLEN-1:0] o_branch_target
);

    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    alu_fn_e         alu_fn;

    // Forwarding source choice for one operand
    function automatic logic [XLEN-1:0] fwd_pick(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs_val = fwd_pick(i_fwd_a, i_rec.rs_data, i_fwd_mem_data, i_fwd_wb_data);
    assign rt_val = fwd_pick(i_fwd_b, i_rec.rt_data, i_fwd_mem_data, i_fwd_wb_data);

    // Shifts operate on rt by shamt
    assign alu_a = i_rec.ex.shift_imm ? rt_val : rs_val;

    always_comb begin
        if (i_rec.ex.shift_imm) begin
            alu_b = {{(XLEN-NB_REG){1'b0}}, i_rec.shamt};
        end else if (i_rec.ex.b_imm) begin
            alu_b = i_rec.imm_ext;
        end else begin
            alu_b = rt_val;
        end
    end

    alu_control u_alu_control (
        .i_alu_op (i_rec.ex.alu_op),
        .i_funct  (i_rec.funct),
        .o_alu_fn (alu_fn)
    );

    alu u_alu (
        .i_alu_fn (alu_fn),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    always_comb begin
        o_ex.alu_result = alu_result;
        o_ex.zero       = alu_zero;
        o_ex.write_data = rt_val;
        o_ex.write_reg  = i_rec.ex.reg_dst ? i_rec.rd : i_rec.rt;
        // Flush turns the item into a bubble downstream
        o_ex.mem        = i_flush ? '0 : i_rec.mem;
        o_ex.wb         = i_flush ? '0 : i_rec.wb;
    end

    // Target lands one cycle after the ALU result
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_branch_target <= '0;
        end else begin
            o_branch_target <= i_rec.pc + XLEN'(4) + (i_rec.imm_ext << 2);
        end
    end

endmodule

//--- run.sh
#!/bin/bash
# Build and run the testbench, then scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exec_subsys -f project.f -o sim_exec \
    > build.log 2>&1 \
    && ./obj_dir/sim_exec > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
